// File: logic/fuse_pkg.sv
/*
 * Fuse controller package
 * Opcodes, result codes, life-cycle states and the partition table
 * shared by the host port and the pipeline stages
 */

package fuse_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  parameter int DATA_W     = 32;
  parameter int PART_COUNT = 4;
  // Last word of each partition holds its digest
  parameter int PART_WORDS = 16;

  parameter int PART_IDX_W = $clog2(PART_COUNT);
  parameter int WORD_IDX_W = $clog2(PART_WORDS);
  parameter int ADDR_W     = $clog2(PART_COUNT * PART_WORDS);

  //////////////////////////////////////////////////
  // Commands and results
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FuseRead   = 2'd0,
    FuseWrite  = 2'd1,
    FuseDigest = 2'd2
  } fuse_cmd_e;

  typedef enum logic [1:0] {
    ErrNone      = 2'd0,
    ErrAccess    = 2'd1,
    ErrLocked    = 2'd2,
    ErrEscalated = 2'd3
  } fuse_err_e;

  // Ordered, so a later state compares greater
  typedef enum logic [2:0] {
    LcRaw     = 3'd0,
    LcTest    = 3'd1,
    LcDev     = 3'd2,
    LcProd    = 3'd3,
    LcProdEnd = 3'd4,
    LcScrap   = 3'd5
  } lc_state_e;

  //////////////////////////////////////////////////
  // Partition table
  //////////////////////////////////////////////////

  typedef struct packed {
    logic      secret;
    lc_state_e lc_phase;
  } part_info_t;

  // Writable up to and including lc_phase
  parameter part_info_t PART_INFO [PART_COUNT] = '{
    '{secret: 1'b1, lc_phase: LcTest},
    '{secret: 1'b0, lc_phase: LcDev},
    '{secret: 1'b1, lc_phase: LcProd},
    '{secret: 1'b0, lc_phase: LcProdEnd}
  };

endpackage

// File: logic/fuse_req_port.sv
/*
 * Fuse host port
 * Four-phase req/ack front end, launches one command at a time
 * and holds the response until the host releases req
 */

`timescale 1ns/1ns

module fuse_req_port
  import fuse_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  // Host side
  input  logic              req_i,
  input  fuse_cmd_e         cmd_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [7:0]        user_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] rdata_o,
  output fuse_err_e         err_o,
  // Pipeline side
  output logic              launch_o,
  output fuse_cmd_e         cmd_o,
  output logic [ADDR_W-1:0] addr_o,
  output logic [DATA_W-1:0] wdata_o,
  output logic [7:0]        user_o,
  input  logic              rsp_valid_i,
  input  logic [DATA_W-1:0] rsp_rdata_i,
  input  fuse_err_e         rsp_err_i
);

  typedef enum logic [1:0] {
    PortIdle,
    PortBusy,
    PortAck,
    PortWaitLow
  } port_state_e;

  port_state_e state_q;

  // Control FSM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= PortIdle;
      launch_o <= 1'b0;
    end else begin
      launch_o <= 1'b0;
      case (state_q)
        PortIdle: begin
          if (req_i) begin
            state_q  <= PortBusy;
            launch_o <= 1'b1;
          end
        end
        PortBusy: begin
          if (rsp_valid_i) begin
            state_q <= PortAck;
          end
        end
        PortAck: begin
          // Host dropped req, release ack on this edge
          if (!req_i) begin
            state_q <= PortWaitLow;
          end
        end
        default: begin
          // One turnaround cycle before a new request is taken
          state_q <= PortIdle;
        end
      endcase
    end
  end

  // Request and response holding registers
  always_ff @(posedge clk_i) begin
    if (state_q == PortIdle && req_i) begin
      cmd_o   <= cmd_i;
      addr_o  <= addr_i;
      wdata_o <= wdata_i;
      user_o  <= user_i;
    end
    if (state_q == PortBusy && rsp_valid_i) begin
      rdata_o <= rsp_rdata_i;
      err_o   <= rsp_err_i;
    end
  end

  assign ack_o = (state_q == PortAck);

endmodule

// File: logic/fuse_access_filter.sv
/*
 * Fuse access filter
 * First pipeline stage, discards programming of the protected
 * low range unless the request comes from the trusted user
 */

`timescale 1ns/1ns

module fuse_access_filter
  import fuse_pkg::*;
#(
  parameter int unsigned PROT_LIMIT   = 8,
  parameter logic [7:0]  TRUSTED_USER = 8'h5a
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  fuse_cmd_e         cmd_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [7:0]        user_i,
  output logic              valid_o,
  output fuse_cmd_e         cmd_o,
  output logic [ADDR_W-1:0] addr_o,
  output logic [DATA_W-1:0] wdata_o,
  output fuse_err_e         err_o
);

  logic is_program;
  logic in_prot_range;
  logic discard;

  assign is_program    = (cmd_i == FuseWrite) || (cmd_i == FuseDigest);
  // Compared at 32 bits so a limit above the address space still works
  assign in_prot_range = (addr_i < PROT_LIMIT);
  assign discard       = is_program && in_prot_range && (user_i != TRUSTED_USER);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // The user ID stops here, later stages only see the verdict
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      cmd_o   <= cmd_i;
      addr_o  <= addr_i;
      wdata_o <= wdata_i;
      err_o   <= discard ? ErrAccess : ErrNone;
    end
  end

endmodule

// File: logic/fuse_part_guard.sv
/*
 * Fuse partition guard
 * Tracks per-partition digest locks and applies life-cycle write
 * locks, digest write locks and secret read locks
 */

`timescale 1ns/1ns

module fuse_part_guard
  import fuse_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  fuse_cmd_e         cmd_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  fuse_err_e         err_i,
  input  lc_state_e         lc_state_i,
  output logic              valid_o,
  output fuse_cmd_e         cmd_o,
  output logic [ADDR_W-1:0] addr_o,
  output logic [DATA_W-1:0] wdata_o,
  output fuse_err_e         err_o
);

  logic [PART_IDX_W-1:0] part_idx;
  logic [WORD_IDX_W-1:0] word_idx;
  logic                  is_digest_word;
  logic                  is_program;
  logic                  lc_expired;
  logic                  secret_read;
  logic [PART_COUNT-1:0] lock_q;
  fuse_err_e             err_d;

  //////////////////////////////////////////////////
  // Address decode and policy
  //////////////////////////////////////////////////

  assign part_idx       = addr_i[ADDR_W-1 -: PART_IDX_W];
  assign word_idx       = addr_i[WORD_IDX_W-1:0];
  assign is_digest_word = (word_idx == WORD_IDX_W'(PART_WORDS - 1));
  assign is_program     = (cmd_i == FuseWrite) || (cmd_i == FuseDigest);

  // Past the partition's programming phase
  assign lc_expired = (lc_state_i > PART_INFO[part_idx].lc_phase);

  // Digest word of a secret partition stays readable after locking
  assign secret_read = (cmd_i == FuseRead) && PART_INFO[part_idx].secret &&
                       lock_q[part_idx] && !is_digest_word;

  always_comb begin
    err_d = err_i;
    // An upstream error passes through untouched
    if (err_i == ErrNone) begin
      if (is_program && (lc_expired || lock_q[part_idx])) begin
        err_d = ErrLocked;
      end else if (secret_read) begin
        err_d = ErrLocked;
      end
    end
  end

  //////////////////////////////////////////////////
  // Digest locks and stage register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      lock_q  <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i && cmd_i == FuseDigest && err_d == ErrNone) begin
        lock_q[part_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      cmd_o   <= cmd_i;
      addr_o  <= addr_i;
      wdata_o <= wdata_i;
      err_o   <= err_d;
    end
  end

endmodule

// File: logic/fuse_array.sv
/*
 * Fuse array
 * Last pipeline stage, holds the fuse words with OR-only programming
 * and enters a sticky terminal state on escalation
 */

`timescale 1ns/1ns

module fuse_array
  import fuse_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  fuse_cmd_e         cmd_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  fuse_err_e         err_i,
  input  logic              escalate_i,
  output logic              rsp_valid_o,
  output logic [DATA_W-1:0] rsp_rdata_o,
  output fuse_err_e         rsp_err_o
);

  localparam int WORD_COUNT = PART_COUNT * PART_WORDS;

  logic [DATA_W-1:0] mem_q [WORD_COUNT];
  logic              esc_q;
  logic              esc_now;
  logic              is_program;
  logic              do_program;
  logic [ADDR_W-1:0] prog_addr;

  // Escalation in the same cycle already counts
  assign esc_now    = esc_q || escalate_i;
  assign is_program = (cmd_i == FuseWrite) || (cmd_i == FuseDigest);
  assign do_program = valid_i && is_program && !esc_now && (err_i == ErrNone);

  // A digest always lands on the partition's last word
  assign prog_addr = (cmd_i == FuseDigest) ?
                     {addr_i[ADDR_W-1 -: PART_IDX_W], WORD_IDX_W'(PART_WORDS - 1)} :
                     addr_i;

  //////////////////////////////////////////////////
  // Fuse storage and terminal state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      esc_q       <= 1'b0;
      rsp_valid_o <= 1'b0;
      for (int i = 0; i < WORD_COUNT; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      rsp_valid_o <= valid_i;
      if (escalate_i) begin
        esc_q <= 1'b1;
      end
      // Bits only ever get blown, never cleared
      if (do_program) begin
        mem_q[prog_addr] <= mem_q[prog_addr] | wdata_i;
      end
    end
  end

  // Response, data only for a clean read
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (esc_now) begin
        rsp_err_o   <= ErrEscalated;
        rsp_rdata_o <= '0;
      end else begin
        rsp_err_o   <= err_i;
        rsp_rdata_o <= (cmd_i == FuseRead && err_i == ErrNone) ? mem_q[addr_i] : '0;
      end
    end
  end

endmodule

// File: logic/fuse_ctrl_top.sv
/*
 * Fuse controller top
 * Host port followed by access filter, partition guard and fuse array
 */

`timescale 1ns/1ns

module fuse_ctrl_top
  import fuse_pkg::*;
#(
  parameter int unsigned PROT_LIMIT   = 8,
  parameter logic [7:0]  TRUSTED_USER = 8'h5a
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  fuse_cmd_e         cmd_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [7:0]        user_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] rdata_o,
  output fuse_err_e         err_o,
  input  lc_state_e         lc_state_i,
  input  logic              escalate_i
);

  // Port to filter
  logic              launch;
  fuse_cmd_e         port_cmd;
  logic [ADDR_W-1:0] port_addr;
  logic [DATA_W-1:0] port_wdata;
  logic [7:0]        port_user;

  // Filter to guard
  logic              filt_valid;
  fuse_cmd_e         filt_cmd;
  logic [ADDR_W-1:0] filt_addr;
  logic [DATA_W-1:0] filt_wdata;
  fuse_err_e         filt_err;

  // Guard to array
  logic              guard_valid;
  fuse_cmd_e         guard_cmd;
  logic [ADDR_W-1:0] guard_addr;
  logic [DATA_W-1:0] guard_wdata;
  fuse_err_e         guard_err;

  // Array back to port
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_rdata;
  fuse_err_e         rsp_err;

  fuse_req_port u_req_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .cmd_i       (cmd_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .user_i      (user_i),
    .ack_o       (ack_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o),
    .launch_o    (launch),
    .cmd_o       (port_cmd),
    .addr_o      (port_addr),
    .wdata_o     (port_wdata),
    .user_o      (port_user),
    .rsp_valid_i (rsp_valid),
    .rsp_rdata_i (rsp_rdata),
    .rsp_err_i   (rsp_err)
  );

  fuse_access_filter #(
    .PROT_LIMIT   (PROT_LIMIT),
    .TRUSTED_USER (TRUSTED_USER)
  ) u_access_filter (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (launch),
    .cmd_i   (port_cmd),
    .addr_i  (port_addr),
    .wdata_i (port_wdata),
    .user_i  (port_user),
    .valid_o (filt_valid),
    .cmd_o   (filt_cmd),
    .addr_o  (filt_addr),
    .wdata_o (filt_wdata),
    .err_o   (filt_err)
  );

  fuse_part_guard u_part_guard (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (filt_valid),
    .cmd_i      (filt_cmd),
    .addr_i     (filt_addr),
    .wdata_i    (filt_wdata),
    .err_i      (filt_err),
    .lc_state_i (lc_state_i),
    .valid_o    (guard_valid),
    .cmd_o      (guard_cmd),
    .addr_o     (guard_addr),
    .wdata_o    (guard_wdata),
    .err_o      (guard_err)
  );

  fuse_array u_fuse_array (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (guard_valid),
    .cmd_i       (guard_cmd),
    .addr_i      (guard_addr),
    .wdata_i     (guard_wdata),
    .err_i       (guard_err),
    .escalate_i  (escalate_i),
    .rsp_valid_o (rsp_valid),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err)
  );

endmodule

// File: tests/fuse_ctrl_sva.sv
/*
 * Fuse controller protocol checker
 * Watches the host handshake and the pipeline nodes inside the DUT
 * and raises fail_o on the first violation
 */

`timescale 1ns/1ns

module fuse_ctrl_sva
  import fuse_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  output logic fail_o
);

  // Index of the current edge counted from the launch edge, 0 when idle
  int        edge_idx;
  logic      ack_q;
  logic      req_q;
  logic      ack_rose;
  logic      access_pend;
  logic      esc_seen;
  logic      esc_pend;
  fuse_err_e want_err;

  task automatic report_violation(input string what);
    $display("Checker violation at %0t ns, %s", $time, what);
    fail_o = 1'b1;
  endtask

  // Everything read here holds the value the DUT flops sample on this edge
  always @(posedge clk_i) begin
    if (rst_i) begin
      edge_idx    = 0;
      ack_q       = 1'b0;
      req_q       = 1'b0;
      access_pend = 1'b0;
      esc_seen    = 1'b0;
      esc_pend    = 1'b0;
      fail_o      = 1'b0;
    end else begin
      // High here means ack_o rose on the previous edge
      ack_rose = fuse_ctrl_tb.DUT.ack_o && !ack_q;

      if (ack_rose && !req_q) begin
        report_violation("ack_o rose while req_i was low");
      end

      // Launch pulse is seen one edge after the launch edge
      if (fuse_ctrl_tb.DUT.u_req_port.launch_o) begin
        edge_idx = 2;
      end else if (edge_idx != 0) begin
        edge_idx = edge_idx + 1;
      end
      if (ack_rose) begin
        if (edge_idx - 1 != 5) begin
          report_violation($sformatf("ack_o rose on edge %0d after launch instead of edge 5",
                                     edge_idx - 1));
        end
        edge_idx = 0;
      end

      ////////////////////////////////////////////////
      // Filter discard must come back as ErrAccess
      ////////////////////////////////////////////////
      if (fuse_ctrl_tb.DUT.u_access_filter.valid_o) begin
        access_pend = (fuse_ctrl_tb.DUT.u_access_filter.err_o == ErrAccess);
      end
      // Escalation is sticky from the first edge that sees escalate_i high
      if (fuse_ctrl_tb.DUT.escalate_i) begin
        esc_seen = 1'b1;
      end
      // Escalation seen when the command reaches the array overrides any earlier verdict
      if (fuse_ctrl_tb.DUT.u_fuse_array.valid_i) begin
        esc_pend = esc_seen;
      end
      if (fuse_ctrl_tb.DUT.u_req_port.rsp_valid_i && access_pend) begin
        want_err = esc_pend ? ErrEscalated : ErrAccess;
        if (fuse_ctrl_tb.DUT.u_req_port.rsp_err_i != want_err) begin
          report_violation("filter discard did not reach the port as ErrAccess");
        end
        access_pend = 1'b0;
      end

      ack_q = fuse_ctrl_tb.DUT.ack_o;
      req_q = fuse_ctrl_tb.DUT.req_i;
    end
  end

endmodule

// File: tests/fuse_ctrl_tb.sv
/*
 * Fuse controller testbench
 * Replays the golden command list through the four-phase host port
 * and compares every response and the handshake timing
 */

`timescale 1ns/1ns

module fuse_ctrl_tb
  import fuse_pkg::*;
();

  localparam int CLK_PERIOD     = 10;
  localparam int RESET_CYCLES   = 4;
  localparam int CYCLES_PER_CMD = 20;

  logic              clk = 1'b0;
  logic              rst;
  logic              req;
  fuse_cmd_e         cmd;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [7:0]        user;
  logic              ack;
  logic [DATA_W-1:0] rdata;
  fuse_err_e         err;
  lc_state_e         lc_state;
  logic              escalate;
  logic              sva_fail;
  int                watch_cycles = 0;

  // Golden commands, one entry per line of the file
  logic [1:0]        cmd_q       [$];
  logic [ADDR_W-1:0] addr_q      [$];
  logic [DATA_W-1:0] wdata_q     [$];
  logic [7:0]        user_q      [$];
  logic [2:0]        lc_q        [$];
  logic              esc_q       [$];
  logic [DATA_W-1:0] exp_rdata_q [$];
  logic [1:0]        exp_err_q   [$];

  fuse_ctrl_top #(
    .PROT_LIMIT   (8),
    .TRUSTED_USER (8'h5a)
  ) DUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (req),
    .cmd_i      (cmd),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .user_i     (user),
    .ack_o      (ack),
    .rdata_o    (rdata),
    .err_o      (err),
    .lc_state_i (lc_state),
    .escalate_i (escalate)
  );

  fuse_ctrl_sva u_sva (
    .clk_i  (clk),
    .rst_i  (rst),
    .fail_o (sva_fail)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Failure handling and checks
  //////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  always @(posedge sva_fail) begin
    stop_with_failure();
  end

  //////////////////////////////////////////////////
  // Golden file and command replay
  //////////////////////////////////////////////////

  task automatic load_golden();
    int          fd;
    int          n;
    int          c;
    logic        done;
    logic [31:0] field [8];
    fd = $fopen("tests/fuse_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file tests/fuse_golden.txt");
      stop_with_failure();
    end
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%h %h %h %h %h %h %h %h", field[0], field[1], field[2],
                  field[3], field[4], field[5], field[6], field[7]);
      if (n == 8) begin
        cmd_q.push_back(field[0][1:0]);
        addr_q.push_back(field[1][ADDR_W-1:0]);
        wdata_q.push_back(field[2]);
        user_q.push_back(field[3][7:0]);
        lc_q.push_back(field[4][2:0]);
        esc_q.push_back(field[5][0]);
        exp_rdata_q.push_back(field[6]);
        exp_err_q.push_back(field[7][1:0]);
      end else if (n == -1 || $feof(fd)) begin
        done = 1'b1;
      end else if (n > 0) begin
        $display("Golden file holds a line with %0d of 8 columns", n);
        stop_with_failure();
      end else begin
        // Comment line, skip to its end
        c = $fgetc(fd);
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_command(input int idx);
    int    cycles;
    string name;
    name = $sformatf("command %0d", idx);
    @(posedge clk);
    #1;
    cmd      = fuse_cmd_e'(cmd_q[idx]);
    addr     = addr_q[idx];
    wdata    = wdata_q[idx];
    user     = user_q[idx];
    lc_state = lc_state_e'(lc_q[idx]);
    escalate = esc_q[idx];
    @(posedge clk);
    #1;
    req    = 1'b1;
    cycles = 0;
    // The launch edge counts as the first
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!ack);
    compare_value({name, " latency"}, 5, cycles);
    compare_value({name, " rdata"}, exp_rdata_q[idx], rdata);
    compare_value({name, " err"}, exp_err_q[idx], err);
    req = 1'b0;
    @(posedge clk);
    #1;
    compare_value({name, " ack release"}, 0, ack);
  endtask

  initial begin
    rst      = 1'b1;
    req      = 1'b0;
    cmd      = FuseRead;
    addr     = '0;
    wdata    = '0;
    user     = '0;
    lc_state = LcRaw;
    escalate = 1'b0;
    load_golden();
    if (cmd_q.size() == 0) begin
      $display("Golden file holds no commands");
      stop_with_failure();
    end
    watch_cycles = cmd_q.size() * CYCLES_PER_CMD + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (cmd_q[i]) begin
      run_command(i);
    end
    if (sva_fail === 1'b1) begin
      stop_with_failure();
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  // Watchdog
  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT never finished the command list",
             watch_cycles);
    stop_with_failure();
  end

endmodule

// File: sources.f
logic/fuse_pkg.sv
logic/fuse_req_port.sv
logic/fuse_access_filter.sv
logic/fuse_part_guard.sv
logic/fuse_array.sv
logic/fuse_ctrl_top.sv
tests/fuse_ctrl_sva.sv
tests/fuse_ctrl_tb.sv

// File: tests/fuse_golden.txt
# cmd addr wdata user lc_state escalate exp_rdata exp_err, all hex
# cmd 0 read 1 write 2 digest, err 0 none 1 access 2 locked 3 escalated
1 12 000000f0 00 0 0 00000000 0
1 12 0000000f 00 0 0 00000000 0
0 12 00000000 00 0 0 000000ff 0
1 12 00000000 00 0 0 00000000 0
0 12 00000000 00 0 0 000000ff 0
1 31 12345678 00 0 0 00000000 0
1 03 0000ffff 11 0 0 00000000 1
0 03 00000000 11 0 0 00000000 0
1 03 0000ffff 5a 0 0 00000000 0
0 03 00000000 11 0 0 0000ffff 0
2 05 0badf00d 11 0 0 00000000 1
1 04 00000001 5a 2 0 00000000 2
1 14 00000001 00 3 0 00000000 2
1 24 00000100 00 3 0 00000000 0
1 04 00000001 5a 5 0 00000000 2
1 14 00000001 00 5 0 00000000 2
1 24 00000001 00 5 0 00000000 2
1 34 00000001 00 5 0 00000000 2
1 22 0000abcd 00 0 0 00000000 0
2 20 c0ffee00 00 0 0 00000000 0
1 22 00000001 00 0 0 00000000 2
0 22 00000000 00 0 0 00000000 2
0 2f 00000000 00 0 0 c0ffee00 0
2 2f 00000001 00 0 0 00000000 2
2 3a 0000beef 00 0 0 00000000 0
1 31 ffffffff 00 0 0 00000000 2
0 31 00000000 00 0 0 12345678 0
0 3f 00000000 00 0 0 0000beef 0
0 12 00000000 00 0 0 000000ff 0
0 12 00000000 00 0 1 00000000 3
0 12 00000000 00 0 0 00000000 3
1 13 00000001 00 0 0 00000000 3
1 03 00000001 11 0 0 00000000 3
